/* sim.f */
verilog/mt32_pkg.sv
verilog/pin_deglitch.sv
verilog/edge_period_meter.sv
verilog/cable_orient.sv
verilog/i2s_receiver.sv
verilog/mt32_audio_top.sv
dv/tb_top.sv

/* Makefile */
# Verilator simulation of the MT-32 audio receive path
# Run from the project root so the pattern file path resolves

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_top \
		-f sim.f --Mdir $(OBJ_DIR) -o Vtb_top

run: compile
	./$(OBJ_DIR)/Vtb_top | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/i2s_patterns.txt */
# Columns: orient (0 straight, 1 crossed), ending ws level (1 left, 0 right),
#          bit count, glitch on bclk (0/1), data bits in hex LSB aligned, expected sample
# Word select levels alternate so that every word ends with a ws change
# Each sample differs from the last one in its channel so the update can be seen

# Straight cable: bclk on pin 6, data on pin 2, ws on pin 5
0 0 16 0 A5C3 A5C3
0 1 16 0 1234 1234
0 0 16 0 FFFF FFFF
0 1 16 0 8001 8001
# Short words, missing low bits read as zero
0 0 12 0 ABC ABC0
0 1 8 0 5A 5A00
# Long words, only the first 16 bits stay
0 0 20 0 F0F0F F0F0
0 1 18 0 2AAAA AAAA
# One-cycle pulse on bclk in every low phase
0 0 16 1 C3A5 C3A5
0 1 16 1 7E81 7E81
# Single bit word
0 0 1 0 1 8000
0 1 16 0 0000 0000

# Crossed cable: bclk on pin 4, data on pin 5, ws on pin 2
# First word follows the all-high preamble, so its data is all ones as well
1 0 16 0 FFFF FFFF
1 1 16 0 A5C3 A5C3
1 0 16 0 1234 1234
1 1 16 0 8001 8001
1 0 12 0 ABC ABC0
1 1 8 0 5A 5A00
1 0 20 0 F0F0F F0F0
1 1 18 0 2AAAA AAAA
1 0 16 1 C3A5 C3A5
1 1 16 1 7E81 7E81
1 0 1 0 1 8000
1 1 16 0 0000 0000

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

	localparam int CNT_W    = 5;
	localparam int SAMPLE_W = 16;

	// Half of the 8 cycle bit clock period
	localparam int HALF_BCLK = 4;

	// Wait limits in CLK_AUDIO cycles
	localparam int WORD_LIMIT  = 64;
	localparam int MIDI_LIMIT  = 8;
	localparam int TRAIN_LIMIT = 32;

	// MIDI line never toggles faster than this
	localparam int MIDI_GAP = 40;

	logic                           CLK_AUDIO;
	logic                           RESET;
	logic [mt32_pkg::PIN_COUNT-1:0] pin_drv;
	mt32_pkg::user_pins_t           user_in;
	mt32_pkg::user_pins_t           user_out;
	logic                           uart_rxd;
	logic                           uart_txd;
	logic [SAMPLE_W-1:0]            audio_l;
	logic [SAMPLE_W-1:0]            audio_r;
	logic                           cable_crossed;

	int   errors;
	int   timeouts;
	int   words;
	int   cycle_cnt;
	int   last_midi;
	int   cur_orient;
	logic cur_ws;
	logic midi_level;

	assign user_in = pin_drv;

	mt32_audio_top #(
		.CNT_W    (CNT_W),
		.SAMPLE_W (SAMPLE_W)
	) dut0 (
		.CLK_AUDIO     (CLK_AUDIO),
		.RESET         (RESET),
		.user_in       (user_in),
		.user_out      (user_out),
		.uart_rxd      (uart_rxd),
		.uart_txd      (uart_txd),
		.audio_l       (audio_l),
		.audio_r       (audio_r),
		.cable_crossed (cable_crossed)
	);

	// 10 ns clock
	initial begin
		CLK_AUDIO = 1'b0;
		forever begin
			#5 CLK_AUDIO = ~CLK_AUDIO;
		end
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	// Step n rising edges and return 1 ns after the last one
	task automatic hold_cycles(input int n);
		repeat (n) begin
			@(posedge CLK_AUDIO);
			cycle_cnt++;
		end
		#1;
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Reset with every open-drain pin released high
	task automatic apply_reset();
		RESET      = 1'b1;
		pin_drv    = '1;
		uart_rxd   = 1'b1;
		midi_level = 1'b1;
		cur_ws     = 1'b1;
		hold_cycles(10);
		RESET     = 1'b0;
		last_midi = cycle_cnt;
		hold_cycles(1);
		check_equal("audio_l", 32'(audio_l), 32'h0);
		check_equal("audio_r", 32'(audio_r), 32'h0);
		check_equal("cable_crossed", 32'(cable_crossed), 32'h0);
	endtask

	// One bit clock period with data and ws changing while bclk is low
	task automatic send_bit(input int orient, input logic data_bit, input logic ws_bit,
		input logic glitch);
		int bclk_pin;
		int data_pin;
		int ws_pin;
		bclk_pin = (orient == 1) ? mt32_pkg::PIN_BCLK_A : mt32_pkg::PIN_SPARE;
		data_pin = (orient == 1) ? mt32_pkg::PIN_DAT_A : mt32_pkg::PIN_WS_A;
		ws_pin   = (orient == 1) ? mt32_pkg::PIN_WS_A : mt32_pkg::PIN_DAT_A;
		pin_drv[bclk_pin] = 1'b0;
		pin_drv[data_pin] = data_bit;
		pin_drv[ws_pin]   = ws_bit;
		if (glitch) begin
			// Single cycle spike in the middle of the low phase
			hold_cycles(1);
			pin_drv[bclk_pin] = 1'b1;
			hold_cycles(1);
			pin_drv[bclk_pin] = 1'b0;
			hold_cycles(HALF_BCLK - 2);
		end else begin
			hold_cycles(HALF_BCLK);
		end
		pin_drv[bclk_pin] = 1'b1;
		hold_cycles(HALF_BCLK);
	endtask

	// MSB first with the new ws level only on the last bit
	task automatic send_word(input int orient, input logic ws_end, input int nbits,
		input logic glitch, input logic [31:0] data);
		for (int i = nbits - 1; i >= 0; i--) begin
			send_bit(orient, data[i], (i == 0) ? ws_end : cur_ws, glitch);
		end
		cur_ws = ws_end;
	endtask

	// Clock-only preamble with ws and data held at the current ws level
	task automatic train_orientation(input int orient);
		int n;
		n = 0;
		while (int'(cable_crossed) != orient && n < TRAIN_LIMIT) begin
			send_bit(orient, cur_ws, cur_ws, 1'b0);
			n++;
		end
		if (int'(cable_crossed) != orient) begin
			timeouts++;
			$display("Timeout: cable orientation %0d not detected after %0d bit clocks",
				orient, n);
		end
	endtask

	// Slow MIDI level change plus a UART receive toggle
	task automatic toggle_midi(input int orient);
		logic [mt32_pkg::PIN_COUNT-1:0] exp_out;
		logic [mt32_pkg::PIN_COUNT-1:0] got_out;
		int                             n;
		if (cycle_cnt - last_midi >= MIDI_GAP) begin
			midi_level = ~midi_level;
			uart_rxd   = ~uart_rxd;
			// MIDI sits on pin 6 when crossed and on pin 4 when straight
			pin_drv[(orient == 1) ? mt32_pkg::PIN_SPARE : mt32_pkg::PIN_BCLK_A] = midi_level;
			last_midi = cycle_cnt;
			n = 0;
			hold_cycles(1);
			while (uart_txd != midi_level && n < MIDI_LIMIT) begin
				hold_cycles(1);
				n++;
			end
			if (uart_txd != midi_level) begin
				timeouts++;
				$display("Timeout: uart_txd did not follow the MIDI pin within %0d cycles", n);
			end
			exp_out = '1;
			exp_out[mt32_pkg::PIN_TX] = uart_rxd;
			got_out = user_out;
			check_equal("user_out", 32'(got_out), 32'(exp_out));
		end
	endtask

	// ==========================================================
	// One pattern line
	// ==========================================================

	task automatic run_pattern(input int orient, input int ws_end, input int nbits,
		input int glitch, input logic [31:0] data, input logic [31:0] exp);
		logic [SAMPLE_W-1:0] prev_l;
		logic [SAMPLE_W-1:0] prev_r;
		int                  n;
		// A new orientation starts from reset
		if (orient != cur_orient) begin
			apply_reset();
			train_orientation(orient);
			cur_orient = orient;
		end
		if ((ws_end != 0) == cur_ws) begin
			errors++;
			$display("Pattern %0d keeps the word select level, so no word end", words);
		end
		// Idle gap with bclk high
		hold_cycles(4 + int'($urandom % 16));
		toggle_midi(orient);
		prev_l = audio_l;
		prev_r = audio_r;
		send_word(orient, ws_end != 0, nbits, glitch != 0, data);
		n = 0;
		while (audio_l == prev_l && audio_r == prev_r && n < WORD_LIMIT) begin
			hold_cycles(1);
			n++;
		end
		if (audio_l == prev_l && audio_r == prev_r) begin
			timeouts++;
			$display("Timeout: no sample update within %0d cycles for word %0d", n, words);
		end else if (ws_end != 0) begin
			check_equal("audio_l", 32'(audio_l), exp);
		end else begin
			check_equal("audio_r", 32'(audio_r), exp);
		end
		check_equal("cable_crossed", 32'(cable_crossed), 32'(orient));
		words++;
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		int          fd;
		int          line_no;
		int          p_orient;
		int          p_ws;
		int          p_bits;
		int          p_glitch;
		logic [31:0] p_data;
		logic [31:0] p_exp;
		string       line;

		RESET     = 1'b1;
		pin_drv   = '1;
		uart_rxd  = 1'b1;
		errors    = 0;
		timeouts  = 0;
		words     = 0;
		cycle_cnt = 0;
		void'($urandom(32'h7c66));

		apply_reset();
		cur_orient = 0;

		fd = $fopen("dv/i2s_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the pattern file dv/i2s_patterns.txt");
		end else begin
			line_no = 0;
			while ($fgets(line, fd) != 0) begin
				line_no++;
				// Skip comments and blank lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%d %d %d %d %h %h", p_orient, p_ws, p_bits, p_glitch,
						p_data, p_exp) != 6 || p_bits < 1 || p_bits > 32) begin
						errors++;
						$display("Pattern line %0d could not be read", line_no);
					end else begin
						run_pattern(p_orient, p_ws, p_bits, p_glitch, p_data, p_exp);
					end
				end
			end
			$fclose(fd);
		end

		$display("Words: %0d, value errors: %0d, timeouts: %0d", words, errors, timeouts);
		if (errors == 0 && timeouts == 0 && words > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog/mt32_audio_top.sv */
`timescale 1ns/1ps

module mt32_audio_top #(
	parameter int CNT_W    = 5,
	parameter int SAMPLE_W = 16
) (
	input  logic                  CLK_AUDIO,
	input  logic                  RESET,
	input  mt32_pkg::user_pins_t  user_in,
	output mt32_pkg::user_pins_t  user_out,
	input  logic                  uart_rxd,
	output logic                  uart_txd,
	output logic [SAMPLE_W-1:0]   audio_l,
	output logic [SAMPLE_W-1:0]   audio_r,
	output logic                  cable_crossed
);

	mt32_pkg::user_pins_t           pins_clean;
	logic [mt32_pkg::PIN_COUNT-1:0] pins_vec;
	logic [1:0][CNT_W-1:0]          period;
	mt32_pkg::orient_t              orient;
	mt32_pkg::i2s_lines_t           lines;

	// ==========================================================
	// Pin conditioning
	// ==========================================================

	pin_deglitch deglitch0 (
		.CLK_AUDIO  (CLK_AUDIO),
		.RESET      (RESET),
		.user_in    (user_in),
		.pins_clean (pins_clean)
	);

	assign pins_vec = pins_clean;

	// Meter 0 on pin 4, meter 1 on pin 6
	// One of them carries bclk, the other MIDI
	for (genvar i = 0; i < 2; i++) begin : rate_meter
		localparam int TAP = (i == 0) ? mt32_pkg::PIN_BCLK_A : mt32_pkg::PIN_SPARE;

		edge_period_meter #(
			.CNT_W (CNT_W)
		) meter (
			.CLK_AUDIO (CLK_AUDIO),
			.RESET     (RESET),
			.pin       (pins_vec[TAP]),
			.period    (period[i])
		);
	end

	// ==========================================================
	// Cable orientation and audio receive
	// ==========================================================

	cable_orient #(
		.CNT_W (CNT_W)
	) orient0 (
		.CLK_AUDIO  (CLK_AUDIO),
		.RESET      (RESET),
		.period_a   (period[0]),
		.period_b   (period[1]),
		.pins_clean (pins_clean),
		.orient     (orient),
		.lines      (lines)
	);

	i2s_receiver #(
		.SAMPLE_W (SAMPLE_W)
	) i2s0 (
		.CLK_AUDIO (CLK_AUDIO),
		.RESET     (RESET),
		.lines     (lines),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	assign cable_crossed = (orient == mt32_pkg::ORIENT_CROSSED);

	// MIDI from the MT32-pi goes straight out on the UART
	assign uart_txd = lines.midi_rx;

	// Open-drain outputs released high so the pins can be read
	// Pin 1 carries MIDI out towards the MT32-pi
	always_comb begin
		user_out    = '1;
		user_out.tx = uart_rxd;
	end

endmodule

/* verilog/i2s_receiver.sv */
`timescale 1ns/1ps

module i2s_receiver #(
	parameter int SAMPLE_W = 16
) (
	input  logic                  CLK_AUDIO,
	input  logic                  RESET,
	input  mt32_pkg::i2s_lines_t  lines,
	output logic [SAMPLE_W-1:0]   audio_l,
	output logic [SAMPLE_W-1:0]   audio_r
);

	// Bit counter must be able to hold SAMPLE_W itself
	localparam int CW = $clog2(SAMPLE_W + 1);

	// Bit clock edge detection
	logic bclk_d;
	logic bclk_rise;

	// Word select as sampled on the last bclk rise
	logic ws_last;

	// Set once ws_last holds a real sample
	logic ws_primed;

	// Raised by a ws change, commits the word on the next cycle
	logic word_end;

	logic [CW-1:0]       bit_cnt;
	logic [SAMPLE_W-1:0] shift_buf;

	assign bclk_rise = lines.bclk & ~bclk_d;

	always_ff @(posedge CLK_AUDIO) begin
		if (RESET) begin
			bclk_d    <= 1'b1;
			ws_last   <= 1'b0;
			ws_primed <= 1'b0;
			word_end  <= 1'b0;
			bit_cnt   <= '0;
			shift_buf <= '0;
			audio_l   <= '0;
			audio_r   <= '0;
		end else begin
			bclk_d <= lines.bclk;

			// ==================================================
			// Bit capture on bclk rise
			// ==================================================
			if (bclk_rise) begin
				// MSB first, extra bits beyond SAMPLE_W are dropped
				if (bit_cnt < CW'(SAMPLE_W)) begin
					shift_buf[SAMPLE_W-1-bit_cnt] <= lines.data;
					bit_cnt <= bit_cnt + 1'b1;
				end

				// ws change on this rise makes it the last bit of the word
				ws_last   <= lines.ws;
				ws_primed <= 1'b1;
				if (ws_primed && (lines.ws != ws_last)) begin
					word_end <= 1'b1;
				end
			end

			// ==================================================
			// Word commit
			// ==================================================
			if (word_end) begin
				word_end  <= 1'b0;
				bit_cnt   <= '0;
				// Unfilled low bits stay zero for the next word
				shift_buf <= '0;

				// High ws at the word end selects the left channel
				if (ws_last) begin
					audio_l <= shift_buf;
				end else begin
					audio_r <= shift_buf;
				end
			end
		end
	end

endmodule

/* verilog/cable_orient.sv */
`timescale 1ns/1ps

module cable_orient #(
	parameter int CNT_W = 5
) (
	input  logic                   CLK_AUDIO,
	input  logic                   RESET,
	input  logic [CNT_W-1:0]       period_a,
	input  logic [CNT_W-1:0]       period_b,
	input  mt32_pkg::user_pins_t   pins_clean,
	output mt32_pkg::orient_t      orient,
	output mt32_pkg::i2s_lines_t   lines
);

	logic [mt32_pkg::PIN_COUNT-1:0] p;
	logic                           both_idle;

	assign p = pins_clean;

	// Neither candidate pin carries a clock
	assign both_idle = (&period_a) && (&period_b);

	// ==========================================================
	// Orientation decision
	// ==========================================================

	// Bit clock is the faster line, MIDI the slow one
	// Pin 4 no slower than pin 6 means the cable is crossed
	always_ff @(posedge CLK_AUDIO) begin
		if (RESET) begin
			orient <= mt32_pkg::ORIENT_STRAIGHT;
		end else if (!both_idle) begin
			// Keep last decision while both lines sit idle
			orient <= (period_a <= period_b) ? mt32_pkg::ORIENT_CROSSED
				: mt32_pkg::ORIENT_STRAIGHT;
		end
	end

	// ==========================================================
	// Line routing
	// ==========================================================

	always_comb begin
		if (orient == mt32_pkg::ORIENT_CROSSED) begin
			// ws on 2, data on 5, bclk on 4, MIDI on 6
			lines.ws      = p[mt32_pkg::PIN_WS_A];
			lines.data    = p[mt32_pkg::PIN_DAT_A];
			lines.bclk    = p[mt32_pkg::PIN_BCLK_A];
			lines.midi_rx = p[mt32_pkg::PIN_SPARE];
		end else begin
			// ws on 5, data on 2, bclk on 6, MIDI on 4
			lines.ws      = p[mt32_pkg::PIN_DAT_A];
			lines.data    = p[mt32_pkg::PIN_WS_A];
			lines.bclk    = p[mt32_pkg::PIN_SPARE];
			lines.midi_rx = p[mt32_pkg::PIN_BCLK_A];
		end
	end

endmodule

/* verilog/edge_period_meter.sv */
`timescale 1ns/1ps

module edge_period_meter #(
	parameter int CNT_W = 5
) (
	input  logic             CLK_AUDIO,
	input  logic             RESET,
	input  logic             pin,
	output logic [CNT_W-1:0] period
);

	// Delayed copy for edge detection
	logic pin_d;
	logic rise;

	// First edge after reset only starts the count
	logic armed;

	// Cycles since the last rising edge, saturating
	logic [CNT_W-1:0] cnt;

	assign rise = pin & ~pin_d;

	always_ff @(posedge CLK_AUDIO) begin
		if (RESET) begin
			// Same idle level as the deglitcher, so no edge right after reset
			pin_d  <= 1'b1;
			armed  <= 1'b0;
			cnt    <= '0;
			period <= '1;
		end else begin
			pin_d <= pin;

			// Count up until all ones
			// A saturated count means an idle or very slow line
			if (!(&cnt)) begin
				cnt <= cnt + 1'b1;
			end else begin
				period <= '1;
			end

			// Rising edge closes the measurement
			if (rise) begin
				cnt   <= '0;
				armed <= 1'b1;
				if (armed) begin
					period <= cnt;
				end
			end
		end
	end

endmodule

/* verilog/pin_deglitch.sv */
`timescale 1ns/1ps

module pin_deglitch (
	input  logic                   CLK_AUDIO,
	input  logic                   RESET,
	input  mt32_pkg::user_pins_t   user_in,
	output mt32_pkg::user_pins_t   pins_clean
);

	// Flat views of the pin structs
	logic [mt32_pkg::PIN_COUNT-1:0] raw;
	logic [mt32_pkg::PIN_COUNT-1:0] sample_q;
	logic [mt32_pkg::PIN_COUNT-1:0] accept_q;

	assign raw = user_in;

	// Two-sample agreement filter
	// The raw pin is compared with the previous sample
	// A level is accepted only once it has been seen on two edges in a row
	always_ff @(posedge CLK_AUDIO) begin
		if (RESET) begin
			// Open-drain lines idle high through the pull-ups
			sample_q <= '1;
			accept_q <= '1;
		end else begin
			sample_q <= raw;
			for (int i = 0; i < mt32_pkg::PIN_COUNT; i++) begin
				// Ringing shorter than one cycle never matches its neighbour
				if (sample_q[i] == raw[i]) begin
					accept_q[i] <= sample_q[i];
				end
			end
		end
	end

	// Stable change shows up two cycles after it hits the pin
	assign pins_clean = accept_q;

endmodule

/* verilog/mt32_pkg.sv */
package mt32_pkg;

	// ==========================================================
	// User port pin map
	// ==========================================================

	// Seven open-drain user-port pins
	localparam int PIN_COUNT = 7;

	// Pin indices, labelled as on the MT32-pi connector
	localparam int PIN_RX     = 0;
	localparam int PIN_TX     = 1;
	localparam int PIN_WS_A   = 2;
	localparam int PIN_SCL    = 3;
	localparam int PIN_BCLK_A = 4;
	localparam int PIN_DAT_A  = 5;
	localparam int PIN_SPARE  = 6;

	// One bit per pin, pin 0 in the LSB so the struct indexes like a vector
	typedef struct packed {
		logic spare;
		logic dat_a;
		logic bclk_a;
		logic scl;
		logic ws_a;
		logic tx;
		logic rx;
	} user_pins_t;

	// ==========================================================
	// Serial audio and MIDI lines after cable routing
	// ==========================================================

	typedef struct packed {
		logic ws;
		logic data;
		logic bclk;
		logic midi_rx;
	} i2s_lines_t;

	// Cable orientation as decided from the bit clock rates
	typedef enum logic {
		ORIENT_STRAIGHT = 1'b0,
		ORIENT_CROSSED  = 1'b1
	} orient_t;

endpackage
